/* src/adder_bk_pkg.sv */
package adder_bk_pkg;

    // Operand width of the adder
    localparam int ADDER_WIDTH = 32;

    // Propagate/generate vectors carry the carry-in at position 0
    localparam int PG_WIDTH = ADDER_WIDTH + 1;

    // Up-sweep depth of the prefix tree, spans 2 up to the largest power of two that fits
    localparam int PG_LEVELS = $clog2(PG_WIDTH + 1) - 1;

    typedef enum logic [1:0] {
        OP_ADD  = 2'b00,
        OP_ADDC = 2'b01,
        OP_SUB  = 2'b10,
        OP_SUBB = 2'b11
    } alu_op_e;

endpackage

/* src/pg_stage_if.sv */
`timescale 1ns/100ps

interface pg_stage_if;

    logic                               valid;
    logic [adder_bk_pkg::PG_WIDTH-1:0]  p;
    logic [adder_bk_pkg::PG_WIDTH-1:0]  g;
    // Sign of a and of the effective (possibly inverted) b
    logic                               a_msb;
    logic                               b_msb;

    modport producer (
        output valid,
        output p,
        output g,
        output a_msb,
        output b_msb
    );

    modport consumer (
        input  valid,
        input  p,
        input  g,
        input  a_msb,
        input  b_msb
    );

endinterface

/* src/operand_prep.sv */
`timescale 1ns/100ps

module operand_prep (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_valid,
    input  adder_bk_pkg::alu_op_e               i_op,
    input  logic [adder_bk_pkg::ADDER_WIDTH-1:0] i_a,
    input  logic [adder_bk_pkg::ADDER_WIDTH-1:0] i_b,
    input  logic                                i_cin,
    pg_stage_if.producer                        o_pg
);

    logic [adder_bk_pkg::ADDER_WIDTH-1:0] b_eff;
    logic                                 cin_eff;
    logic [adder_bk_pkg::PG_WIDTH-1:0]    p_next;
    logic [adder_bk_pkg::PG_WIDTH-1:0]    g_next;

    // Subtraction is a + ~b + 1, borrow-in turns into an inverted carry-in
    always_comb begin
        b_eff   = i_b;
        cin_eff = 1'b0;
        case (i_op)
            adder_bk_pkg::OP_ADD: begin
                b_eff   = i_b;
                cin_eff = 1'b0;
            end
            adder_bk_pkg::OP_ADDC: begin
                b_eff   = i_b;
                cin_eff = i_cin;
            end
            adder_bk_pkg::OP_SUB: begin
                b_eff   = ~i_b;
                cin_eff = 1'b1;
            end
            adder_bk_pkg::OP_SUBB: begin
                b_eff   = ~i_b;
                cin_eff = ~i_cin;
            end
            default: begin
                b_eff   = i_b;
                cin_eff = 1'b0;
            end
        endcase
    end

    // Carry-in enters as a generate with no propagate at position 0
    assign p_next = {i_a ^ b_eff, 1'b0};
    assign g_next = {i_a & b_eff, cin_eff};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pg.valid <= 1'b0;
            o_pg.p     <= '0;
            o_pg.g     <= '0;
            o_pg.a_msb <= 1'b0;
            o_pg.b_msb <= 1'b0;
        end else begin
            o_pg.valid <= i_valid;
            o_pg.p     <= p_next;
            o_pg.g     <= g_next;
            o_pg.a_msb <= i_a[adder_bk_pkg::ADDER_WIDTH-1];
            o_pg.b_msb <= b_eff[adder_bk_pkg::ADDER_WIDTH-1];
        end
    end

endmodule

/* src/brent_kung_group_pg.sv */
`timescale 1ns/100ps

module brent_kung_group_pg (
    input  logic [adder_bk_pkg::PG_WIDTH-1:0] i_p,
    input  logic [adder_bk_pkg::PG_WIDTH-1:0] i_g,
    output logic [adder_bk_pkg::PG_WIDTH-1:0] o_gg,
    output logic [adder_bk_pkg::PG_WIDTH-1:0] o_pp
);

    // Up-sweep
    // Level k combines blocks of span 2**k ending at positions i with (i+1) a multiple of 2**k
    for (genvar k = 0; k <= adder_bk_pkg::PG_LEVELS; k++) begin : g_up
        logic [adder_bk_pkg::PG_WIDTH-1:0] g;
        logic [adder_bk_pkg::PG_WIDTH-1:0] p;

        if (k == 0) begin : g_leaf
            assign g = i_g;
            assign p = i_p;
        end else begin : g_node
            for (genvar i = 0; i < adder_bk_pkg::PG_WIDTH; i++) begin : g_bit
                if (((i + 1) % (1 << k)) == 0) begin : g_black
                    assign g[i] = g_up[k-1].g[i]
                                | (g_up[k-1].p[i] & g_up[k-1].g[i - (1 << (k - 1))]);
                    assign p[i] = g_up[k-1].p[i] & g_up[k-1].p[i - (1 << (k - 1))];
                end else begin : g_pass
                    assign g[i] = g_up[k-1].g[i];
                    assign p[i] = g_up[k-1].p[i];
                end
            end
        end
    end

    // Down-sweep
    // Fill in the positions halfway between finished prefixes, widest span first
    for (genvar d = 0; d < adder_bk_pkg::PG_LEVELS; d++) begin : g_dn
        logic [adder_bk_pkg::PG_WIDTH-1:0] g;

        if (d == 0) begin : g_root
            assign g = g_up[adder_bk_pkg::PG_LEVELS].g;
        end else begin : g_node
            for (genvar i = 0; i < adder_bk_pkg::PG_WIDTH; i++) begin : g_bit
                if ((((i + 1) % (1 << (adder_bk_pkg::PG_LEVELS - d)))
                        == (1 << (adder_bk_pkg::PG_LEVELS - d - 1)))
                        && (i >= (1 << (adder_bk_pkg::PG_LEVELS - d)))) begin : g_gray
                    // Block propagate from the up-sweep, prefix below it already known
                    assign g[i] = g_dn[d-1].g[i]
                                | (g_up[adder_bk_pkg::PG_LEVELS].p[i]
                                   & g_dn[d-1].g[i - (1 << (adder_bk_pkg::PG_LEVELS - d - 1))]);
                end else begin : g_pass
                    assign g[i] = g_dn[d-1].g[i];
                end
            end
        end
    end

    // Every position now holds the group generate from position 0
    assign o_gg = g_dn[adder_bk_pkg::PG_LEVELS-1].g;

    // Block propagate of each tree node, position 0 passes straight through
    assign o_pp = g_up[adder_bk_pkg::PG_LEVELS].p;

endmodule

/* src/sum_flags_stage.sv */
`timescale 1ns/100ps

module sum_flags_stage (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    pg_stage_if.consumer                         i_pg,
    output logic                                 o_valid,
    output logic [adder_bk_pkg::ADDER_WIDTH-1:0] o_sum,
    output logic                                 o_carry,
    output logic                                 o_overflow,
    output logic                                 o_zero
);

    logic [adder_bk_pkg::PG_WIDTH-1:0]    carry;
    logic [adder_bk_pkg::ADDER_WIDTH-1:0] sum_next;
    logic                                 overflow_next;

    brent_kung_group_pg brent_kung_group_pg_inst (
        .i_p  (i_pg.p),
        .i_g  (i_pg.g),
        .o_gg (carry),
        .o_pp ()
    );

    // carry[i] is the carry into operand bit i, propagate for bit i sits at i+1
    assign sum_next = i_pg.p[adder_bk_pkg::PG_WIDTH-1:1] ^ carry[adder_bk_pkg::ADDER_WIDTH-1:0];

    // Same as carry into msb xor carry out
    assign overflow_next = (i_pg.a_msb ~^ i_pg.b_msb)
                         & (sum_next[adder_bk_pkg::ADDER_WIDTH-1] ^ i_pg.a_msb);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid    <= 1'b0;
            o_sum      <= '0;
            o_carry    <= 1'b0;
            o_overflow <= 1'b0;
            o_zero     <= 1'b0;
        end else begin
            o_valid    <= i_pg.valid;
            o_sum      <= sum_next;
            // Raw carry out, after subtraction 1 means no borrow
            o_carry    <= carry[adder_bk_pkg::ADDER_WIDTH];
            o_overflow <= overflow_next;
            o_zero     <= ~|sum_next;
        end
    end

endmodule

/* src/adder_bk_top.sv */
`timescale 1ns/100ps

module adder_bk_top (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_valid,
    input  adder_bk_pkg::alu_op_e                i_op,
    input  logic [adder_bk_pkg::ADDER_WIDTH-1:0] i_a,
    input  logic [adder_bk_pkg::ADDER_WIDTH-1:0] i_b,
    input  logic                                 i_cin,
    output logic                                 o_valid,
    output logic [adder_bk_pkg::ADDER_WIDTH-1:0] o_sum,
    output logic                                 o_carry,
    output logic                                 o_overflow,
    output logic                                 o_zero
);

    // Registered slot between the two pipeline stages
    pg_stage_if pg_stage ();

    operand_prep operand_prep_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_op    (i_op),
        .i_a     (i_a),
        .i_b     (i_b),
        .i_cin   (i_cin),
        .o_pg    (pg_stage.producer)
    );

    sum_flags_stage sum_flags_stage_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_pg       (pg_stage.consumer),
        .o_valid    (o_valid),
        .o_sum      (o_sum),
        .o_carry    (o_carry),
        .o_overflow (o_overflow),
        .o_zero     (o_zero)
    );

endmodule

/* test/adder_bk_properties.sv */
`timescale 1ns/100ps

module adder_bk_properties (
    input logic                                 i_clk,
    input logic                                 i_rst_n,
    input logic                                 i_valid,
    input adder_bk_pkg::alu_op_e                i_op,
    input logic [adder_bk_pkg::ADDER_WIDTH-1:0] i_a,
    input logic [adder_bk_pkg::ADDER_WIDTH-1:0] i_b,
    input logic                                 i_cin,
    input logic                                 i_out_valid,
    input logic [adder_bk_pkg::ADDER_WIDTH-1:0] i_sum,
    input logic                                 i_carry,
    input logic                                 i_overflow,
    input logic                                 i_zero
);

    int fail_count = 0;

    logic [adder_bk_pkg::ADDER_WIDTH:0]   full;
    logic [adder_bk_pkg::ADDER_WIDTH:0]   sa;
    logic [adder_bk_pkg::ADDER_WIDTH:0]   sb;
    logic [adder_bk_pkg::ADDER_WIDTH:0]   extra;
    logic [adder_bk_pkg::ADDER_WIDTH:0]   sfull;
    logic [adder_bk_pkg::ADDER_WIDTH-1:0] exp_sum;
    logic                                 exp_carry;
    logic                                 exp_overflow;
    logic                                 is_sub;

    always_comb begin
        is_sub = (i_op == adder_bk_pkg::OP_SUB) || (i_op == adder_bk_pkg::OP_SUBB);
        case (i_op)
            adder_bk_pkg::OP_ADD:  full = {1'b0, i_a} + {1'b0, i_b};
            adder_bk_pkg::OP_ADDC: full = {1'b0, i_a} + {1'b0, i_b}
                                        + {{adder_bk_pkg::ADDER_WIDTH{1'b0}}, i_cin};
            adder_bk_pkg::OP_SUB:  full = {1'b0, i_a} - {1'b0, i_b};
            default:               full = {1'b0, i_a} - {1'b0, i_b}
                                        - {{adder_bk_pkg::ADDER_WIDTH{1'b0}}, i_cin};
        endcase
        exp_sum = full[adder_bk_pkg::ADDER_WIDTH-1:0];
        // A borrow wraps the difference and clears the carry
        exp_carry = is_sub ? ~full[adder_bk_pkg::ADDER_WIDTH] : full[adder_bk_pkg::ADDER_WIDTH];
        // Sign-extended operands keep the signed result within 33 bits
        sa    = {i_a[adder_bk_pkg::ADDER_WIDTH-1], i_a};
        sb    = {i_b[adder_bk_pkg::ADDER_WIDTH-1], i_b};
        extra = ((i_op == adder_bk_pkg::OP_ADDC) || (i_op == adder_bk_pkg::OP_SUBB))
              ? {{adder_bk_pkg::ADDER_WIDTH{1'b0}}, i_cin} : '0;
        sfull = is_sub ? (sa - sb - extra) : (sa + sb + extra);
        exp_overflow = sfull[adder_bk_pkg::ADDER_WIDTH] != sfull[adder_bk_pkg::ADDER_WIDTH-1];
    end

    a_valid_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid == $past(i_valid, 2))
    else begin
        fail_count = fail_count + 1;
        $error("o_valid does not follow i_valid two cycles later");
    end

    a_result: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid |-> (i_sum == $past(exp_sum, 2)) && (i_carry == $past(exp_carry, 2))
                        && (i_overflow == $past(exp_overflow, 2)))
    else begin
        fail_count = fail_count + 1;
        $error("sum, carry or overflow does not match the operation two cycles earlier");
    end

    a_zero_flag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid |-> (i_zero == (i_sum == '0)))
    else begin
        fail_count = fail_count + 1;
        $error("o_zero disagrees with o_sum");
    end

    a_reset_clears: assert property (@(posedge i_clk) !i_rst_n |-> !i_out_valid)
    else begin
        fail_count = fail_count + 1;
        $error("o_valid high while reset is asserted");
    end

endmodule

/* test/adder_bk_tb.sv */
`timescale 1ns/100ps

module adder_bk_tb;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 valid;
    adder_bk_pkg::alu_op_e                op;
    logic [adder_bk_pkg::ADDER_WIDTH-1:0] a;
    logic [adder_bk_pkg::ADDER_WIDTH-1:0] b;
    logic                                 cin;
    logic                                 dut_valid;
    logic [adder_bk_pkg::ADDER_WIDTH-1:0] dut_sum;
    logic                                 dut_carry;
    logic                                 dut_overflow;
    logic                                 dut_zero;

    // Expected {sum, carry, overflow, zero} in issue order
    logic [adder_bk_pkg::ADDER_WIDTH+2:0] exp_q[$];
    logic [adder_bk_pkg::ADDER_WIDTH+2:0] exp_head;
    logic [31:0]                          lfsr_state;
    int                                   err_count;
    int                                   checked;
    int                                   test_num;
    int                                   test_base;

    adder_bk_top adder_bk_top_inst (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_valid    (valid),
        .i_op       (op),
        .i_a        (a),
        .i_b        (b),
        .i_cin      (cin),
        .o_valid    (dut_valid),
        .o_sum      (dut_sum),
        .o_carry    (dut_carry),
        .o_overflow (dut_overflow),
        .o_zero     (dut_zero)
    );

    bind adder_bk_top adder_bk_properties adder_bk_properties_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_op        (i_op),
        .i_a         (i_a),
        .i_b         (i_b),
        .i_cin       (i_cin),
        .i_out_valid (o_valid),
        .i_sum       (o_sum),
        .i_carry     (o_carry),
        .i_overflow  (o_overflow),
        .i_zero      (o_zero)
    );

    always #5 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic take_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [adder_bk_pkg::ADDER_WIDTH-1:0] take_word();
        logic [adder_bk_pkg::ADDER_WIDTH-1:0] word;
        word = '0;
        for (int i = 0; i < adder_bk_pkg::ADDER_WIDTH; i++) begin
            word = {word[adder_bk_pkg::ADDER_WIDTH-2:0], take_bit()};
        end
        return word;
    endfunction

    function automatic adder_bk_pkg::alu_op_e take_op();
        logic [1:0]            sel;
        adder_bk_pkg::alu_op_e pick;
        sel = {take_bit(), take_bit()};
        case (sel)
            2'b00:   pick = adder_bk_pkg::OP_ADD;
            2'b01:   pick = adder_bk_pkg::OP_ADDC;
            2'b10:   pick = adder_bk_pkg::OP_SUB;
            default: pick = adder_bk_pkg::OP_SUBB;
        endcase
        return pick;
    endfunction

    // Reference model in 64-bit arithmetic with unsigned carry and signed overflow
    function automatic logic [adder_bk_pkg::ADDER_WIDTH+2:0] expected_result(
        input adder_bk_pkg::alu_op_e                f_op,
        input logic [adder_bk_pkg::ADDER_WIDTH-1:0] f_a,
        input logic [adder_bk_pkg::ADDER_WIDTH-1:0] f_b,
        input logic                                 f_cin
    );
        logic [63:0]                          ua;
        logic [63:0]                          ub;
        logic [63:0]                          sa;
        logic [63:0]                          sb;
        logic [63:0]                          extra;
        logic [63:0]                          ures;
        logic [63:0]                          sres;
        logic [adder_bk_pkg::ADDER_WIDTH-1:0] sum;
        logic                                 carry;
        logic                                 overflow;
        ua = {{(64-adder_bk_pkg::ADDER_WIDTH){1'b0}}, f_a};
        ub = {{(64-adder_bk_pkg::ADDER_WIDTH){1'b0}}, f_b};
        sa = {{(64-adder_bk_pkg::ADDER_WIDTH){f_a[adder_bk_pkg::ADDER_WIDTH-1]}}, f_a};
        sb = {{(64-adder_bk_pkg::ADDER_WIDTH){f_b[adder_bk_pkg::ADDER_WIDTH-1]}}, f_b};
        extra = '0;
        if ((f_op == adder_bk_pkg::OP_ADDC) || (f_op == adder_bk_pkg::OP_SUBB)) begin
            extra = {63'b0, f_cin};
        end
        if ((f_op == adder_bk_pkg::OP_ADD) || (f_op == adder_bk_pkg::OP_ADDC)) begin
            ures  = ua + ub + extra;
            sres  = sa + sb + extra;
            carry = ures[adder_bk_pkg::ADDER_WIDTH];
        end else begin
            ures  = ua - ub - extra;
            sres  = sa - sb - extra;
            // Negative difference means a borrow
            carry = ~ures[63];
        end
        sum = ures[adder_bk_pkg::ADDER_WIDTH-1:0];
        overflow = (sres != {{(64-adder_bk_pkg::ADDER_WIDTH){sres[adder_bk_pkg::ADDER_WIDTH-1]}},
                             sres[adder_bk_pkg::ADDER_WIDTH-1:0]});
        return {sum, carry, overflow, sum == '0};
    endfunction

    function automatic int total_errors();
        return err_count + adder_bk_top_inst.adder_bk_properties_inst.fail_count;
    endfunction

    task automatic check_word(input string name,
                              input logic [adder_bk_pkg::ADDER_WIDTH-1:0] expected,
                              input logic [adder_bk_pkg::ADDER_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("error at %0d ns: %s expected %h actual %h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error at %0d ns: %s expected %b actual %b", $time, name, expected, actual);
            err_count++;
        end
    endtask

    // Outputs are compared at the falling edge away from register updates
    always @(negedge clk) begin
        if (rst_n && dut_valid) begin
            if (exp_q.size() == 0) begin
                $display("o_valid went high at %0d ns with no operation outstanding", $time);
                err_count++;
            end else begin
                exp_head = exp_q.pop_front();
                check_word("o_sum", exp_head[adder_bk_pkg::ADDER_WIDTH+2:3], dut_sum);
                check_bit("o_carry", exp_head[2], dut_carry);
                check_bit("o_overflow", exp_head[1], dut_overflow);
                check_bit("o_zero", exp_head[0], dut_zero);
                checked++;
            end
        end
    end

    task automatic drive_cycle(input logic t_valid, input adder_bk_pkg::alu_op_e t_op,
                               input logic [adder_bk_pkg::ADDER_WIDTH-1:0] t_a,
                               input logic [adder_bk_pkg::ADDER_WIDTH-1:0] t_b, input logic t_cin);
        @(posedge clk);
        #1;
        valid = t_valid;
        op    = t_op;
        a     = t_a;
        b     = t_b;
        cin   = t_cin;
        if (t_valid) begin
            exp_q.push_back(expected_result(t_op, t_a, t_b, t_cin));
        end
    endtask

    task automatic issue_random(input adder_bk_pkg::alu_op_e t_op);
        drive_cycle(1'b1, t_op, take_word(), take_word(), take_bit());
    endtask

    task automatic drain(input int max_cycles);
        int waited;
        waited = 0;
        drive_cycle(1'b0, adder_bk_pkg::OP_ADD, '0, '0, 1'b0);
        while ((exp_q.size() != 0) && (waited < max_cycles)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results never came out within %0d cycles",
                     exp_q.size(), max_cycles);
            err_count++;
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, total_errors() - test_base);
        test_base = total_errors();
    endtask

    task automatic test_edge_cases();
        logic [adder_bk_pkg::ADDER_WIDTH-1:0] word;
        logic [adder_bk_pkg::ADDER_WIDTH-1:0] other;
        // Carry ripples through every prefix level
        drive_cycle(1'b1, adder_bk_pkg::OP_ADDC, '1, '0, 1'b1);
        drive_cycle(1'b1, adder_bk_pkg::OP_ADDC, '1, '0, 1'b0);
        drive_cycle(1'b1, adder_bk_pkg::OP_ADDC, '0, '1, 1'b1);
        for (int i = 0; i < 10; i++) begin
            issue_random(adder_bk_pkg::OP_ADDC);
        end
        drain(20);
        report_test("add with carry");
        for (int i = 0; i < 20; i++) begin
            issue_random(adder_bk_pkg::OP_SUB);
            issue_random(adder_bk_pkg::OP_SUBB);
        end
        word = take_word();
        drive_cycle(1'b1, adder_bk_pkg::OP_SUB, word, word, 1'b0);
        drive_cycle(1'b1, adder_bk_pkg::OP_SUBB, word, word, 1'b1);
        drive_cycle(1'b1, adder_bk_pkg::OP_SUB, '0, 1, 1'b0);
        drain(20);
        report_test("subtract and borrow");
        drive_cycle(1'b1, adder_bk_pkg::OP_ADD, 32'h7fff_ffff, 1, 1'b0);
        drive_cycle(1'b1, adder_bk_pkg::OP_SUB, 32'h8000_0000, 1, 1'b0);
        for (int i = 0; i < 20; i++) begin
            word  = take_word();
            other = take_word();
            drive_cycle(1'b1, adder_bk_pkg::OP_ADD, word & 32'h7fff_ffff,
                        other | 32'h8000_0000, 1'b0);
        end
        drain(20);
        report_test("signed overflow");
    endtask

    task automatic test_stream_and_reset();
        for (int i = 0; i < 64; i++) begin
            // Roughly one cycle in four is idle
            drive_cycle(~(take_bit() & take_bit()), take_op(), take_word(), take_word(), take_bit());
        end
        drain(20);
        report_test("streaming with gaps");
        for (int i = 0; i < 4; i++) begin
            issue_random(take_op());
        end
        check_bit("o_valid", 1'b1, dut_valid);
        rst_n = 1'b0;
        valid = 1'b0;
        #1;
        check_bit("o_valid", 1'b0, dut_valid);
        exp_q.delete();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < 8; i++) begin
            issue_random(take_op());
        end
        drain(20);
        report_test("reset in mid-stream");
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        valid      = 1'b0;
        op         = adder_bk_pkg::OP_ADD;
        a          = '0;
        b          = '0;
        cin        = 1'b0;
        lfsr_state = 32'heb5f;
        err_count  = 0;
        checked    = 0;
        test_num   = 0;
        test_base  = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < 40; i++) begin
            issue_random(adder_bk_pkg::OP_ADD);
        end
        drain(20);
        report_test("random add");
        test_edge_cases();
        test_stream_and_reset();
        $display("%0d tests, %0d results checked, %0d errors", test_num, checked, total_errors());
        if (total_errors() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* adder_bk.f */
src/adder_bk_pkg.sv
src/pg_stage_if.sv
src/operand_prep.sv
src/brent_kung_group_pg.sv
src/sum_flags_stage.sv
src/adder_bk_top.sv
test/adder_bk_properties.sv
test/adder_bk_tb.sv

/* Makefile */
TOP := adder_bk_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f adder_bk.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f adder_bk.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
